/* logic/rcc_pkg.sv */
// rcc shared definitions
`default_nettype none

package rcc_pkg;

  // ========================================
  // apb bus geometry
  // ========================================
  localparam int APB_AW = 4;
  localparam int APB_DW = 32;

  // prescaler counter width, covers divide by 256
  localparam int RATIO_MAX_W = 8;

  // ========================================
  // prescaler codes and allocation
  // ========================================
  // top bit clear means divide by 1
  typedef logic [3:0] hpre_t;
  typedef logic [2:0] ppre_t;

  // one bit per bus a sleeping cpu keeps alive
  typedef logic [2:0] alloc_t;

  localparam int ALLOC_AHB1 = 0;
  localparam int ALLOC_APB1 = 1;
  localparam int ALLOC_APB2 = 2;

  // ========================================
  // register map
  // ========================================
  localparam logic [APB_AW-1:0] CFGR_OFS  = 4'h0;
  localparam logic [APB_AW-1:0] ALLOC_OFS = 4'h4;

  // cfgr fields
  localparam int HPRE_LSB  = 0;
  localparam int PPRE1_LSB = 4;
  localparam int PPRE2_LSB = 8;

  // alloc fields
  localparam int C1_ALLOC_LSB = 0;
  localparam int C2_ALLOC_LSB = 4;

endpackage

`default_nettype wire

/* logic/rcc_apb_regs.sv */
// rcc apb register file
`default_nettype none
`timescale 1ns/1ps

module rcc_apb_regs (
  input  logic                       i_clk,
  input  logic                       i_arst_n,
  // apb slave
  input  logic                       i_psel,
  input  logic                       i_penable,
  input  logic                       i_pwrite,
  input  logic [rcc_pkg::APB_AW-1:0] i_paddr,
  input  logic [rcc_pkg::APB_DW-1:0] i_pwdata,
  output logic [rcc_pkg::APB_DW-1:0] o_prdata,
  output logic                       o_pready,
  output logic                       o_pslverr,
  // configuration
  output rcc_pkg::hpre_t             o_hpre,
  output rcc_pkg::ppre_t             o_ppre1,
  output rcc_pkg::ppre_t             o_ppre2,
  output rcc_pkg::alloc_t            o_c1_alloc,
  output rcc_pkg::alloc_t            o_c2_alloc
);
  import rcc_pkg::*;

  logic access;
  logic sel_cfgr;
  logic sel_alloc;
  logic addr_hit;

  // ========================================
  // address decode
  // ========================================
  assign access    = i_psel & i_penable;
  assign sel_cfgr  = (i_paddr == CFGR_OFS);
  assign sel_alloc = (i_paddr == ALLOC_OFS);
  assign addr_hit  = sel_cfgr | sel_alloc;

  // every access finishes in its first access cycle
  assign o_pready  = 1'b1;
  assign o_pslverr = access & ~addr_hit;

  // ========================================
  // registers
  // ========================================
  // written on the edge that closes the access phase
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_hpre     <= '0;
      o_ppre1    <= '0;
      o_ppre2    <= '0;
      o_c1_alloc <= '0;
      o_c2_alloc <= '0;
    end else if (access && i_pwrite) begin
      if (sel_cfgr) begin
        o_hpre  <= i_pwdata[HPRE_LSB +: $bits(hpre_t)];
        o_ppre1 <= i_pwdata[PPRE1_LSB +: $bits(ppre_t)];
        o_ppre2 <= i_pwdata[PPRE2_LSB +: $bits(ppre_t)];
      end
      if (sel_alloc) begin
        o_c1_alloc <= i_pwdata[C1_ALLOC_LSB +: $bits(alloc_t)];
        o_c2_alloc <= i_pwdata[C2_ALLOC_LSB +: $bits(alloc_t)];
      end
    end
  end

  // read mux, unused bits and unmapped offsets give zero
  always_comb begin
    o_prdata = '0;
    if (sel_cfgr) begin
      o_prdata[HPRE_LSB +: $bits(hpre_t)]  = o_hpre;
      o_prdata[PPRE1_LSB +: $bits(ppre_t)] = o_ppre1;
      o_prdata[PPRE2_LSB +: $bits(ppre_t)] = o_ppre2;
    end
    if (sel_alloc) begin
      o_prdata[C1_ALLOC_LSB +: $bits(alloc_t)] = o_c1_alloc;
      o_prdata[C2_ALLOC_LSB +: $bits(alloc_t)] = o_c2_alloc;
    end
  end

endmodule

`default_nettype wire

/* logic/rcc_prescaler.sv */
// programmable tick prescaler
`default_nettype none
`timescale 1ns/1ps

module rcc_prescaler #(
  parameter type code_t = rcc_pkg::hpre_t
) (
  input  logic  i_clk,
  input  logic  i_arst_n,
  input  logic  i_tick,
  input  code_t i_code,
  output logic  o_tick
);
  import rcc_pkg::*;

  // top bit enables division, the rest is the exponent
  localparam int CODE_W = $bits(code_t);
  localparam int EXP_W  = CODE_W - 1;

  typedef logic [RATIO_MAX_W:0]   ratio_t;
  typedef logic [RATIO_MAX_W-1:0] cnt_t;

  ratio_t ratio;
  cnt_t   last;
  cnt_t   cnt;
  code_t  code_q;
  logic   code_chg;

  // ========================================
  // ratio decode
  // ========================================
  always_comb begin
    if (i_code[CODE_W-1]) begin
      ratio = ratio_t'(2) << i_code[EXP_W-1:0];
    end else begin
      ratio = ratio_t'(1);
    end
    // terminal count, 0 for divide by 1
    last = cnt_t'(ratio - ratio_t'(1));
  end

  assign code_chg = (i_code != code_q);

  // ========================================
  // tick counter
  // ========================================
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      code_q <= '0;
      cnt    <= '0;
      o_tick <= 1'b0;
    end else begin
      code_q <= i_code;
      if (code_chg) begin
        // restart the count with the new ratio
        cnt    <= '0;
        o_tick <= 1'b0;
      end else if (i_tick) begin
        if (cnt == last) begin
          cnt    <= '0;
          o_tick <= 1'b1;
        end else begin
          cnt    <= cnt + cnt_t'(1);
          o_tick <= 1'b0;
        end
      end else begin
        o_tick <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/rcc_gate_ctrl.sv */
// rcc clock enable gating
`default_nettype none
`timescale 1ns/1ps

module rcc_gate_ctrl (
  input  logic            i_clk,
  input  logic            i_arst_n,
  // ticks from the prescaler chain
  input  logic            i_hclk_tick,
  input  logic            i_pclk1_tick,
  input  logic            i_pclk2_tick,
  // cpu power state
  input  logic            i_c1_sleep,
  input  logic            i_c1_deepsleep,
  input  logic            i_c2_sleep,
  input  logic            i_c2_deepsleep,
  // bridge activity
  input  logic            i_ahb1_busy,
  input  logic            i_apb1_busy,
  input  logic            i_apb2_busy,
  input  logic            i_sys_stop,
  input  rcc_pkg::alloc_t i_c1_alloc,
  input  rcc_pkg::alloc_t i_c2_alloc,
  // enables
  output logic            o_hclk_en,
  output logic            o_c1_clk_en,
  output logic            o_c2_clk_en,
  output logic            o_ahb1_clk_en,
  output logic            o_apb1_clk_en,
  output logic            o_apb2_clk_en
);
  import rcc_pkg::*;

  logic run;
  logic c1_sleep_mode;
  logic c2_sleep_mode;
  logic c1_gate;
  logic c2_gate;
  logic apb1_gate;
  logic apb2_gate;
  logic ahb1_gate;
  logic hclk_tick_q;

  // ========================================
  // gate terms
  // ========================================
  assign run           = ~i_sys_stop;
  assign c1_sleep_mode = i_c1_sleep & ~i_c1_deepsleep;
  assign c2_sleep_mode = i_c2_sleep & ~i_c2_deepsleep;

  assign c1_gate = ~i_c1_sleep & ~i_c1_deepsleep;
  assign c2_gate = ~i_c2_sleep & ~i_c2_deepsleep;

  // bus stays on for an awake cpu2, a sleeping owner or pending traffic
  assign apb1_gate = ~i_c2_sleep | (c2_sleep_mode & i_c2_alloc[ALLOC_APB1])
                   | (c1_sleep_mode & i_c1_alloc[ALLOC_APB1]) | i_apb1_busy;
  assign apb2_gate = ~i_c2_sleep | (c2_sleep_mode & i_c2_alloc[ALLOC_APB2])
                   | (c1_sleep_mode & i_c1_alloc[ALLOC_APB2]) | i_apb2_busy;

  // both apb bridges hang off ahb1
  assign ahb1_gate = ~i_c2_sleep | (c2_sleep_mode & i_c2_alloc[ALLOC_AHB1])
                   | (c1_sleep_mode & i_c1_alloc[ALLOC_AHB1]) | i_ahb1_busy
                   | apb1_gate | apb2_gate;

  // ========================================
  // registered enables
  // ========================================
  // hclk tick is held back one stage to line up with the apb prescaler output
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      hclk_tick_q   <= 1'b0;
      o_hclk_en     <= 1'b0;
      o_c1_clk_en   <= 1'b0;
      o_c2_clk_en   <= 1'b0;
      o_ahb1_clk_en <= 1'b0;
      o_apb1_clk_en <= 1'b0;
      o_apb2_clk_en <= 1'b0;
    end else begin
      hclk_tick_q   <= i_hclk_tick;
      o_hclk_en     <= hclk_tick_q & run;
      o_c1_clk_en   <= hclk_tick_q & c1_gate & run;
      o_c2_clk_en   <= hclk_tick_q & c2_gate & run;
      o_ahb1_clk_en <= hclk_tick_q & ahb1_gate & run;
      o_apb1_clk_en <= i_pclk1_tick & apb1_gate & run;
      o_apb2_clk_en <= i_pclk2_tick & apb2_gate & run;
    end
  end

endmodule

`default_nettype wire

/* logic/rcc_clk_en_top.sv */
// rcc clock enable top
`default_nettype none
`timescale 1ns/1ps

module rcc_clk_en_top (
  input  logic                       i_clk,
  input  logic                       i_arst_n,
  // apb slave
  input  logic                       i_psel,
  input  logic                       i_penable,
  input  logic                       i_pwrite,
  input  logic [rcc_pkg::APB_AW-1:0] i_paddr,
  input  logic [rcc_pkg::APB_DW-1:0] i_pwdata,
  output logic [rcc_pkg::APB_DW-1:0] o_prdata,
  output logic                       o_pready,
  output logic                       o_pslverr,
  // cpu and bus state
  input  logic                       i_c1_sleep,
  input  logic                       i_c1_deepsleep,
  input  logic                       i_c2_sleep,
  input  logic                       i_c2_deepsleep,
  input  logic                       i_ahb1_busy,
  input  logic                       i_apb1_busy,
  input  logic                       i_apb2_busy,
  input  logic                       i_sys_stop,
  // enables
  output logic                       o_hclk_en,
  output logic                       o_c1_clk_en,
  output logic                       o_c2_clk_en,
  output logic                       o_ahb1_clk_en,
  output logic                       o_apb1_clk_en,
  output logic                       o_apb2_clk_en
);
  import rcc_pkg::*;

  hpre_t  hpre;
  ppre_t  ppre1;
  ppre_t  ppre2;
  alloc_t c1_alloc;
  alloc_t c2_alloc;
  logic   hclk_tick;
  logic   pclk1_tick;
  logic   pclk2_tick;

  rcc_apb_regs u_regs (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_psel     (i_psel),
    .i_penable  (i_penable),
    .i_pwrite   (i_pwrite),
    .i_paddr    (i_paddr),
    .i_pwdata   (i_pwdata),
    .o_prdata   (o_prdata),
    .o_pready   (o_pready),
    .o_pslverr  (o_pslverr),
    .o_hpre     (hpre),
    .o_ppre1    (ppre1),
    .o_ppre2    (ppre2),
    .o_c1_alloc (c1_alloc),
    .o_c2_alloc (c2_alloc)
  );

  // ========================================
  // prescaler chain
  // ========================================
  // system clock ticks every cycle
  rcc_prescaler #(
    .code_t (hpre_t)
  ) u_ahb_pre (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_tick   (1'b1),
    .i_code   (hpre),
    .o_tick   (hclk_tick)
  );

  rcc_prescaler #(
    .code_t (ppre_t)
  ) u_apb1_pre (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_tick   (hclk_tick),
    .i_code   (ppre1),
    .o_tick   (pclk1_tick)
  );

  rcc_prescaler #(
    .code_t (ppre_t)
  ) u_apb2_pre (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_tick   (hclk_tick),
    .i_code   (ppre2),
    .o_tick   (pclk2_tick)
  );

  rcc_gate_ctrl u_gate (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_hclk_tick    (hclk_tick),
    .i_pclk1_tick   (pclk1_tick),
    .i_pclk2_tick   (pclk2_tick),
    .i_c1_sleep     (i_c1_sleep),
    .i_c1_deepsleep (i_c1_deepsleep),
    .i_c2_sleep     (i_c2_sleep),
    .i_c2_deepsleep (i_c2_deepsleep),
    .i_ahb1_busy    (i_ahb1_busy),
    .i_apb1_busy    (i_apb1_busy),
    .i_apb2_busy    (i_apb2_busy),
    .i_sys_stop     (i_sys_stop),
    .i_c1_alloc     (c1_alloc),
    .i_c2_alloc     (c2_alloc),
    .o_hclk_en      (o_hclk_en),
    .o_c1_clk_en    (o_c1_clk_en),
    .o_c2_clk_en    (o_c2_clk_en),
    .o_ahb1_clk_en  (o_ahb1_clk_en),
    .o_apb1_clk_en  (o_apb1_clk_en),
    .o_apb2_clk_en  (o_apb2_clk_en)
  );

endmodule

`default_nettype wire

/* test/tb_clk_rst.sv */
// testbench clock and reset
`default_nettype none
`timescale 1ns/1ps

module tb_clk_rst (
  output logic o_clk,
  output logic o_arst_n
);

  // 10 ns period
  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  // reset held over the first three edges
  initial begin
    o_arst_n = 1'b0;
    repeat (3) @(posedge o_clk);
    #1;
    o_arst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* test/tb_checker.sv */
// enable checker and reference model
`default_nettype none
`timescale 1ns/1ps

module tb_checker (
  input logic i_clk,
  input logic i_arst_n,
  input logic i_c1_sleep,
  input logic i_c1_deepsleep,
  input logic i_c2_sleep,
  input logic i_c2_deepsleep,
  input logic i_ahb1_busy,
  input logic i_apb1_busy,
  input logic i_apb2_busy,
  input logic i_sys_stop,
  input logic i_hclk_en,
  input logic i_c1_clk_en,
  input logic i_c2_clk_en,
  input logic i_ahb1_clk_en,
  input logic i_apb1_clk_en,
  input logic i_apb2_clk_en
);
  import rcc_pkg::*;

  logic [5:0] en_vec;
  logic       stop_q;
  int         tot [6];
  int         base [6];
  int         cnt [6];
  int         live_err = 0;
  int         chk_err = 0;
  int         test_cnt = 0;
  int         test_fail = 0;
  int         test_start_err = 0;
  string      test_name;

  // index 0 hclk, then c1, c2, ahb1, apb1, apb2
  assign en_vec = {i_apb2_clk_en, i_apb1_clk_en, i_ahb1_clk_en,
                   i_c2_clk_en, i_c1_clk_en, i_hclk_en};

  // ========================================
  // running totals and cycle checks
  // ========================================
  always @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      stop_q <= 1'b0;
      for (int k = 0; k < 6; k++) begin
        tot[k] <= 0;
      end
    end else begin
      stop_q <= i_sys_stop;
      for (int k = 0; k < 6; k++) begin
        tot[k] <= tot[k] + int'(en_vec[k]);
      end
      // outputs seen here were registered with the stop sampled one edge back
      if (stop_q && en_vec != 6'h0) begin
        $display("FAIL enables got 0x%02h expected 0x00 after stop", en_vec);
        live_err <= live_err + 1;
      end
      if ((en_vec[3] | en_vec[4] | en_vec[5]) && !en_vec[0]) begin
        $display("FAIL o_hclk_en got 0x0 expected 0x1 under bus enables 0x%h", en_vec[5:3]);
        live_err <= live_err + 1;
      end
    end
  end

  // ========================================
  // model
  // ========================================
  function automatic int ahb_ratio(input hpre_t code);
    if (code[3]) begin
      return 1 << (int'(code[2:0]) + 1);
    end
    return 1;
  endfunction

  function automatic int apb_ratio(input ppre_t code);
    if (code[2]) begin
      return 1 << (int'(code[1:0]) + 1);
    end
    return 1;
  endfunction

  // expected gate per enable index, from the inputs held right now
  function automatic logic [5:0] model_gates(input alloc_t a1, input alloc_t a2);
    logic c1_nap;
    logic c2_nap;
    logic c2_up;
    logic g_apb1;
    logic g_apb2;
    logic g_ahb1;
    c1_nap = i_c1_sleep && !i_c1_deepsleep;
    c2_nap = i_c2_sleep && !i_c2_deepsleep;
    c2_up  = !i_c2_sleep;
    g_apb1 = c2_up || (c2_nap && a2[1]) || (c1_nap && a1[1]) || i_apb1_busy;
    g_apb2 = c2_up || (c2_nap && a2[2]) || (c1_nap && a1[2]) || i_apb2_busy;
    g_ahb1 = c2_up || (c2_nap && a2[0]) || (c1_nap && a1[0]) || i_ahb1_busy
             || g_apb1 || g_apb2;
    return {g_apb2, g_apb1, g_ahb1, !i_c2_sleep && !i_c2_deepsleep,
            !i_c1_sleep && !i_c1_deepsleep, 1'b1} & {6{!i_sys_stop}};
  endfunction

  function automatic string en_label(input int k);
    case (k)
      0:       return "o_hclk_en";
      1:       return "o_c1_clk_en";
      2:       return "o_c2_clk_en";
      3:       return "o_ahb1_clk_en";
      4:       return "o_apb1_clk_en";
      default: return "o_apb2_clk_en";
    endcase
  endfunction

  function automatic int error_count();
    return chk_err + live_err;
  endfunction

  // ========================================
  // comparisons
  // ========================================
  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      chk_err++;
    end
  endtask

  task automatic check_near(input string name, input int got, input int exp);
    if (got < exp - 1 || got > exp + 1) begin
      $display("FAIL %s got 0x%0h expected 0x%0h within one", name, got, exp);
      chk_err++;
    end
  endtask

  task automatic note_error(input string msg);
    $display("%s", msg);
    chk_err++;
  endtask

  task automatic check_read(input logic [31:0] rdata, input logic err,
                            input logic [31:0] exp_data, input logic exp_err);
    check_eq("o_prdata", rdata, exp_data);
    check_eq("o_pslverr", 32'(err), 32'(exp_err));
  endtask

  task automatic start_window();
    for (int k = 0; k < 6; k++) begin
      base[k] = tot[k];
    end
  endtask

  task automatic stop_window();
    for (int k = 0; k < 6; k++) begin
      cnt[k] = tot[k] - base[k];
    end
  endtask

  task automatic check_division(input hpre_t h, input ppre_t p1, input ppre_t p2,
                                input int cycles);
    check_near(en_label(0), cnt[0], cycles / ahb_ratio(h));
    check_near(en_label(4), cnt[4], cnt[0] / apb_ratio(p1));
    check_near(en_label(5), cnt[5], cnt[0] / apb_ratio(p2));
  endtask

  task automatic check_gating(input hpre_t h, input alloc_t a1, input alloc_t a2,
                              input int cycles);
    logic [5:0] g;
    g = model_gates(a1, a2);
    check_near(en_label(0), cnt[0], cycles / ahb_ratio(h));
    // apb codes at divide by 1, so every enable follows the hclk tick
    for (int k = 1; k < 6; k++) begin
      check_eq(en_label(k), cnt[k], g[k] ? cnt[0] : 0);
    end
  endtask

  task automatic check_stopped();
    for (int k = 0; k < 6; k++) begin
      check_eq(en_label(k), cnt[k], 32'h0);
    end
  endtask

  task automatic check_latency(input hpre_t h, input int n);
    if (n > ahb_ratio(h) + 2) begin
      $display("FAIL o_hclk_en resume latency got 0x%0h expected at most 0x%0h",
               n, ahb_ratio(h) + 2);
      chk_err++;
    end
  endtask

  // ========================================
  // test bookkeeping
  // ========================================
  task automatic begin_test(input string name);
    test_name      = name;
    test_start_err = error_count();
  endtask

  task automatic end_test();
    test_cnt++;
    if (error_count() == test_start_err) begin
      $display("test %s: ok", test_name);
    end else begin
      test_fail++;
      $display("test %s: failed with %0d errors", test_name, error_count() - test_start_err);
    end
  endtask

  task automatic report();
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             test_cnt, test_cnt - test_fail, test_fail, error_count());
  endtask

endmodule

`default_nettype wire

/* test/rcc_props.sv */
// gate control assertions
`default_nettype none
`timescale 1ns/1ps

module rcc_props (
  input logic i_clk,
  input logic i_arst_n,
  input logic i_sys_stop,
  input logic i_hclk_en,
  input logic i_c1_clk_en,
  input logic i_c2_clk_en,
  input logic i_ahb1_clk_en,
  input logic i_apb1_clk_en,
  input logic i_apb2_clk_en
);

  // stop holds every enable low one cycle later
  a_stop_blocks: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_sys_stop |=> !(i_hclk_en | i_c1_clk_en | i_c2_clk_en
                     | i_ahb1_clk_en | i_apb1_clk_en | i_apb2_clk_en))
    else $error("an enable was high in the cycle after a stop cycle");

  // bus enables sit on an hclk pulse
  a_ahb1_on_hclk: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_ahb1_clk_en |-> i_hclk_en)
    else $error("ahb1 enable without an hclk enable");

  a_apb1_on_hclk: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_apb1_clk_en |-> i_hclk_en)
    else $error("apb1 enable without an hclk enable");

  a_apb2_on_hclk: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_apb2_clk_en |-> i_hclk_en)
    else $error("apb2 enable without an hclk enable");

endmodule

bind rcc_gate_ctrl rcc_props u_props (
  .i_clk         (i_clk),
  .i_arst_n      (i_arst_n),
  .i_sys_stop    (i_sys_stop),
  .i_hclk_en     (o_hclk_en),
  .i_c1_clk_en   (o_c1_clk_en),
  .i_c2_clk_en   (o_c2_clk_en),
  .i_ahb1_clk_en (o_ahb1_clk_en),
  .i_apb1_clk_en (o_apb1_clk_en),
  .i_apb2_clk_en (o_apb2_clk_en)
);

`default_nettype wire

/* test/tb_top.sv */
// rcc clock enable testbench
`default_nettype none
`timescale 1ns/1ps

module tb_top;
  import rcc_pkg::*;

  localparam int WINDOW   = 1024;
  localparam int WAIT_MAX = 300;
  // register, prescaler and gate stages
  localparam int SETTLE   = 3;

  logic              clk;
  logic              arst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_AW-1:0] paddr;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;
  logic              c1_sleep;
  logic              c1_deepsleep;
  logic              c2_sleep;
  logic              c2_deepsleep;
  logic              ahb1_busy;
  logic              apb1_busy;
  logic              apb2_busy;
  logic              sys_stop;
  logic              hclk_en;
  logic              c1_clk_en;
  logic              c2_clk_en;
  logic              ahb1_clk_en;
  logic              apb1_clk_en;
  logic              apb2_clk_en;
  integer            seed = 32'heb52b09c;

  tb_clk_rst u_clk_rst (
    .o_clk    (clk),
    .o_arst_n (arst_n)
  );

  rcc_clk_en_top DUT (
    .i_clk          (clk),
    .i_arst_n       (arst_n),
    .i_psel         (psel),
    .i_penable      (penable),
    .i_pwrite       (pwrite),
    .i_paddr        (paddr),
    .i_pwdata       (pwdata),
    .o_prdata       (prdata),
    .o_pready       (pready),
    .o_pslverr      (pslverr),
    .i_c1_sleep     (c1_sleep),
    .i_c1_deepsleep (c1_deepsleep),
    .i_c2_sleep     (c2_sleep),
    .i_c2_deepsleep (c2_deepsleep),
    .i_ahb1_busy    (ahb1_busy),
    .i_apb1_busy    (apb1_busy),
    .i_apb2_busy    (apb2_busy),
    .i_sys_stop     (sys_stop),
    .o_hclk_en      (hclk_en),
    .o_c1_clk_en    (c1_clk_en),
    .o_c2_clk_en    (c2_clk_en),
    .o_ahb1_clk_en  (ahb1_clk_en),
    .o_apb1_clk_en  (apb1_clk_en),
    .o_apb2_clk_en  (apb2_clk_en)
  );

  tb_checker u_chk (
    .i_clk          (clk),
    .i_arst_n       (arst_n),
    .i_c1_sleep     (c1_sleep),
    .i_c1_deepsleep (c1_deepsleep),
    .i_c2_sleep     (c2_sleep),
    .i_c2_deepsleep (c2_deepsleep),
    .i_ahb1_busy    (ahb1_busy),
    .i_apb1_busy    (apb1_busy),
    .i_apb2_busy    (apb2_busy),
    .i_sys_stop     (sys_stop),
    .i_hclk_en      (hclk_en),
    .i_c1_clk_en    (c1_clk_en),
    .i_c2_clk_en    (c2_clk_en),
    .i_ahb1_clk_en  (ahb1_clk_en),
    .i_apb1_clk_en  (apb1_clk_en),
    .i_apb2_clk_en  (apb2_clk_en)
  );

  // ========================================
  // apb driver and waits
  // ========================================
  // every task returns 1 ns after a rising edge
  task automatic apb_access(input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [APB_DW-1:0] wdata,
                            output logic [APB_DW-1:0] rdata, output logic err);
    int n;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    // sample mid-cycle
    #4;
    // no wait states expected in the first access cycle
    u_chk.check_eq("o_pready", 32'(pready), 32'h1);
    n = 0;
    while (!pready) begin
      if (n == WAIT_MAX) begin
        u_chk.note_error("timeout: APB access never saw PREADY");
        break;
      end
      @(posedge clk);
      #5;
      n++;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
    logic [APB_DW-1:0] rdata;
    logic              err;
    apb_access(1'b1, addr, data, rdata, err);
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] rdata,
                          output logic err);
    apb_access(1'b0, addr, '0, rdata, err);
  endtask

  task automatic settle();
    repeat (SETTLE) @(posedge clk);
    #1;
  endtask

  task automatic write_cfgr(input hpre_t h, input ppre_t p1, input ppre_t p2);
    apb_write(CFGR_OFS, {21'h0, p2, 1'b0, p1, h});
    settle();
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (!arst_n) begin
      if (n == WAIT_MAX) begin
        u_chk.note_error("timeout: reset was never released");
        return;
      end
      @(posedge clk);
      n++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic wait_hclk_en(output int n);
    n = 0;
    while (!hclk_en) begin
      if (n == WAIT_MAX) begin
        u_chk.note_error("timeout: o_hclk_en never pulsed");
        return;
      end
      @(posedge clk);
      #1;
      n++;
    end
  endtask

  task automatic measure(input int cycles);
    u_chk.start_window();
    repeat (cycles) @(posedge clk);
    #1;
    u_chk.stop_window();
  endtask

  // ========================================
  // test sequence
  // ========================================
  initial begin
    logic [APB_DW-1:0] wdata;
    logic [APB_DW-1:0] rdata;
    logic [APB_DW-1:0] cfgr_exp;
    logic              err;
    logic [APB_AW-1:0] bad;
    hpre_t             h;
    ppre_t             p1;
    ppre_t             p2;
    alloc_t            a1;
    alloc_t            a2;
    int                n;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    c1_sleep     = 1'b0;
    c1_deepsleep = 1'b0;
    c2_sleep     = 1'b0;
    c2_deepsleep = 1'b0;
    ahb1_busy    = 1'b0;
    apb1_busy    = 1'b0;
    apb2_busy    = 1'b0;
    sys_stop     = 1'b0;
    cfgr_exp     = '0;
    wait_reset();

    u_chk.begin_test("register access");
    repeat (4) begin
      wdata = $random(seed);
      apb_write(CFGR_OFS, wdata);
      apb_read(CFGR_OFS, rdata, err);
      cfgr_exp = wdata & 32'h0000_077f;
      u_chk.check_read(rdata, err, cfgr_exp, 1'b0);
      wdata = $random(seed);
      apb_write(ALLOC_OFS, wdata);
      apb_read(ALLOC_OFS, rdata, err);
      u_chk.check_read(rdata, err, wdata & 32'h0000_0077, 1'b0);
    end
    bad = 4'($random(seed));
    if (bad == CFGR_OFS || bad == ALLOC_OFS) begin
      bad = bad + 4'h1;
    end
    apb_access(1'b1, bad, $random(seed), rdata, err);
    u_chk.check_eq("o_pslverr", 32'(err), 32'h1);
    apb_read(bad, rdata, err);
    u_chk.check_read(rdata, err, 32'h0, 1'b1);
    // the stray write must leave the mapped registers alone
    apb_read(CFGR_OFS, rdata, err);
    u_chk.check_read(rdata, err, cfgr_exp, 1'b0);
    u_chk.end_test();

    u_chk.begin_test("ahb division");
    repeat (6) begin
      h = 4'($random(seed));
      write_cfgr(h, 3'h0, 3'h0);
      wait_hclk_en(n);
      measure(WINDOW);
      u_chk.check_division(h, 3'h0, 3'h0, WINDOW);
    end
    u_chk.end_test();

    u_chk.begin_test("apb division");
    repeat (6) begin
      // ahb divide kept at 16 or below for enough hclk pulses
      h  = 4'($random(seed)) & 4'hb;
      p1 = 3'($random(seed));
      p2 = 3'($random(seed));
      write_cfgr(h, p1, p2);
      wait_hclk_en(n);
      measure(WINDOW);
      u_chk.check_division(h, p1, p2, WINDOW);
    end
    u_chk.end_test();

    u_chk.begin_test("sleep gating");
    repeat (10) begin
      h  = 4'($random(seed)) & 4'hb;
      a1 = 3'($random(seed));
      a2 = 3'($random(seed));
      write_cfgr(h, 3'h0, 3'h0);
      apb_write(ALLOC_OFS, {25'h0, a2, 1'b0, a1});
      {c1_sleep, c1_deepsleep, c2_sleep, c2_deepsleep} = 4'($random(seed));
      // busy kept sparse so the sleep terms decide most gates
      {ahb1_busy, apb1_busy, apb2_busy} = 3'($random(seed) & $random(seed));
      settle();
      measure(512);
      u_chk.check_gating(h, a1, a2, 512);
    end
    {c1_sleep, c1_deepsleep, c2_sleep, c2_deepsleep} = 4'h0;
    {ahb1_busy, apb1_busy, apb2_busy} = 3'h0;
    u_chk.end_test();

    u_chk.begin_test("stop");
    repeat (3) begin
      h = 4'($random(seed));
      write_cfgr(h, 3'($random(seed)), 3'($random(seed)));
      sys_stop = 1'b1;
      settle();
      measure(256);
      u_chk.check_stopped();
      sys_stop = 1'b0;
      wait_hclk_en(n);
      u_chk.check_latency(h, n);
    end
    u_chk.end_test();

    u_chk.report();
    if (u_chk.error_count() == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
logic/rcc_pkg.sv
logic/rcc_apb_regs.sv
logic/rcc_prescaler.sv
logic/rcc_gate_ctrl.sv
logic/rcc_clk_en_top.sv
test/tb_clk_rst.sv
test/tb_checker.sv
test/rcc_props.sv
test/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the rcc clock enable testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_top -f filelist.f -o tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "RESULT: PASS" <<< "$output"; then
  exit 0
fi
exit 1
